// File: hdl/bus_config.svh
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

//////////////////////////////////////////////////
// bus geometry
//////////////////////////////////////////////////

// address width, word addressed
`define BUS_ADR 8
// data width
`define BUS_DAT 32
// bits per byte
`define BUS_UNT 8
// byte enable count
`define BUS_BEN (`BUS_DAT / `BUS_UNT)

//////////////////////////////////////////////////
// memory and slice
//////////////////////////////////////////////////

// implemented words, anything above is an error
`define BUS_MEM_DEPTH 64
// hold register granularity in bytes
`define BUS_GRN 1

`endif

// File: hdl/bus_pkg.sv
`default_nettype none

`include "bus_config.svh"

package bus_pkg;

  //////////////////////////////////////////////////
  // data word
  //////////////////////////////////////////////////

  // one data word seen two ways
  typedef union packed {
    // whole word, read data and compare
    logic [`BUS_DAT-1:0]               wrd;
    // per byte, indexed like the byte enables
    logic [`BUS_BEN-1:0][`BUS_UNT-1:0] byt;
  } bus_wdt_u;

  //////////////////////////////////////////////////
  // request and response
  //////////////////////////////////////////////////

  // request from manager
  typedef struct packed {
    // write enable
    logic                wen;
    // word address
    logic [`BUS_ADR-1:0] adr;
    // byte enables
    logic [`BUS_BEN-1:0] ben;
    // write data
    bus_wdt_u            wdt;
  } bus_req_t;

  // response toward manager
  typedef struct packed {
    // read data, zero on writes and errors
    logic [`BUS_DAT-1:0] rdt;
    // address out of range
    logic                err;
  } bus_rsp_t;

endpackage : bus_pkg

`default_nettype wire

// File: hdl/bus_reg_backpressure.sv
`default_nettype none

`include "bus_config.svh"

module bus_reg_backpressure
  import bus_pkg::*;
#(
  // hold granularity in bytes
  parameter int unsigned GRN = 1
) (
  input  logic     sub,
  input  logic     arst_n,
  // manager side
  input  logic     sub_vld,
  input  bus_req_t sub_req,
  output logic     sub_rdy,
  // subordinate side
  output logic     man_vld,
  output bus_req_t man_req,
  input  logic     man_rdy
);

  //////////////////////////////////////////////////
  // hold register
  //////////////////////////////////////////////////

  // stalled request
  bus_req_t hld_req;
  // accepted while downstream busy
  logic     hld_load;

  assign hld_load = sub_vld & sub_rdy & ~man_rdy;

  // payload only, no reset
  always_ff @(posedge sub) begin
    if (hld_load) begin
      hld_req.wen <= sub_req.wen;
      hld_req.adr <= sub_req.adr;
      hld_req.ben <= sub_req.ben;
      // copy only granules whose first byte is enabled
      for (int unsigned g = 0; g < `BUS_BEN / GRN; g++) begin
        if (sub_req.wen && sub_req.ben[g*GRN]) begin
          for (int unsigned k = 0; k < GRN; k++) begin
            hld_req.wdt.byt[g*GRN+k] <= sub_req.wdt.byt[g*GRN+k];
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // request mux
  //////////////////////////////////////////////////

  // pass through while ready, else replay held request
  assign man_vld = sub_rdy ? sub_vld : 1'b1;
  assign man_req = sub_rdy ? sub_req : hld_req;

  //////////////////////////////////////////////////
  // registered ready
  //////////////////////////////////////////////////

  // no comb path from man_rdy to sub_rdy
  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      sub_rdy <= 1'b1;
    end else if (sub_rdy) begin
      // drop after a capture
      sub_rdy <= ~(sub_vld & ~man_rdy);
    end else begin
      // held request leaves when man_rdy is high
      sub_rdy <= man_rdy;
    end
  end

endmodule : bus_reg_backpressure

`default_nettype wire

// File: hdl/bus_sram.sv
`default_nettype none

`include "bus_config.svh"

module bus_sram
  import bus_pkg::*;
(
  input  logic     sub,
  input  logic     arst_n,
  // request
  input  logic     mem_vld,
  input  bus_req_t mem_req,
  output logic     mem_rdy,
  // response, one cycle after transfer
  output logic     rsp_vld,
  output bus_rsp_t rsp
);

  // index bits for the implemented depth
  localparam int unsigned IDX = $clog2(`BUS_MEM_DEPTH);

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  // storage array
  bus_wdt_u mem [`BUS_MEM_DEPTH];
  // accepted request this cycle
  logic           xfer;
  // address inside the array
  logic           in_rng;
  // array index
  logic [IDX-1:0] idx;

  assign xfer   = mem_vld & mem_rdy;
  assign in_rng = (mem_req.adr < `BUS_MEM_DEPTH);
  assign idx    = mem_req.adr[IDX-1:0];

  //////////////////////////////////////////////////
  // array access
  //////////////////////////////////////////////////

  // byte enable write through the byte view
  always_ff @(posedge sub) begin
    if (xfer && mem_req.wen && in_rng) begin
      for (int unsigned b = 0; b < `BUS_BEN; b++) begin
        if (mem_req.ben[b]) begin
          mem[idx].byt[b] <= mem_req.wdt.byt[b];
        end
      end
    end
  end

  // response payload, loaded per transfer
  always_ff @(posedge sub) begin
    if (xfer) begin
      // out of range flags error
      rsp.err <= ~in_rng;
      // reads in range return the word
      if (!mem_req.wen && in_rng) begin
        rsp.rdt <= mem[idx].wrd;
      end else begin
        // writes and errors give zero
        rsp.rdt <= '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // response strobe
  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= xfer;
    end
  end

  // write recovery, refuse the cycle after a write
  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      mem_rdy <= 1'b1;
    end else begin
      mem_rdy <= ~(xfer & mem_req.wen);
    end
  end

endmodule : bus_sram

`default_nettype wire

// File: hdl/bus_rsp_stage.sv
`default_nettype none

module bus_rsp_stage
  import bus_pkg::*;
(
  input  logic     sub,
  input  logic     arst_n,
  // from the SRAM
  input  logic     in_vld,
  input  bus_rsp_t in_rsp,
  // toward the manager
  output logic     out_vld,
  output bus_rsp_t out_rsp
);

  //////////////////////////////////////////////////
  // strobe
  //////////////////////////////////////////////////

  // one register cycle on valid
  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= in_vld;
    end
  end

  //////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////

  // hold data between responses
  always_ff @(posedge sub) begin
    if (in_vld) begin
      out_rsp <= in_rsp;
    end
  end

endmodule : bus_rsp_stage

`default_nettype wire

// File: hdl/bus_subsystem.sv
`default_nettype none

`include "bus_config.svh"

module bus_subsystem
  import bus_pkg::*;
(
  input  logic     sub,
  input  logic     arst_n,
  // request port
  input  logic     req_vld,
  input  bus_req_t req,
  output logic     req_rdy,
  // response port
  output logic     rsp_vld,
  output bus_rsp_t rsp
);

  //////////////////////////////////////////////////
  // internal links
  //////////////////////////////////////////////////

  // slice to SRAM
  logic     mem_vld;
  bus_req_t mem_req;
  logic     mem_rdy;
  // SRAM to response stage
  logic     sram_rsp_vld;
  bus_rsp_t sram_rsp;

  //////////////////////////////////////////////////
  // instances
  //////////////////////////////////////////////////

  // input side, breaks the ready path
  bus_reg_backpressure #(
    .GRN (`BUS_GRN)
  ) i_slice (
    .sub     (sub),
    .arst_n  (arst_n),
    .sub_vld (req_vld),
    .sub_req (req),
    .sub_rdy (req_rdy),
    .man_vld (mem_vld),
    .man_req (mem_req),
    .man_rdy (mem_rdy)
  );

  // memory
  bus_sram i_sram (
    .sub     (sub),
    .arst_n  (arst_n),
    .mem_vld (mem_vld),
    .mem_req (mem_req),
    .mem_rdy (mem_rdy),
    .rsp_vld (sram_rsp_vld),
    .rsp     (sram_rsp)
  );

  // output side
  bus_rsp_stage i_rsp (
    .sub     (sub),
    .arst_n  (arst_n),
    .in_vld  (sram_rsp_vld),
    .in_rsp  (sram_rsp),
    .out_vld (rsp_vld),
    .out_rsp (rsp)
  );

endmodule : bus_subsystem

`default_nettype wire

// File: tb/tb_bus_subsystem.sv
`default_nettype none

`include "bus_config.svh"

module tb_bus_subsystem
  import bus_pkg::*;
();

  // index bits into the model array
  localparam int unsigned IDX = $clog2(`BUS_MEM_DEPTH);
  // cycles a wait loop may spin
  localparam int TMO = 200;

  logic     sub = 1'b1;
  logic     arst_n;
  logic     req_vld;
  bus_req_t req;
  logic     req_rdy;
  logic     rsp_vld;
  bus_rsp_t rsp;
  // set by a wait loop that ran out of cycles
  logic     hung = 1'b0;

  //////////////////////////////////////////////////
  // clock and DUT
  //////////////////////////////////////////////////

  // 40 unit period
  always #20 sub = ~sub;

  bus_subsystem i_dut (
    .sub     (sub),
    .arst_n  (arst_n),
    .req_vld (req_vld),
    .req     (req),
    .req_rdy (req_rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  //////////////////////////////////////////////////
  // reference models
  //////////////////////////////////////////////////

  // memory contents as the bus rules define them
  logic [`BUS_DAT-1:0] ref_mem [`BUS_MEM_DEPTH];
  // responses still owed, oldest first
  bus_rsp_t exp_q [$];
  bus_rsp_t exp_head;
  int       exp_cnt;
  // traffic counters
  int       xfer_cnt = 0;
  int       rsp_cnt = 0;
  int       stall_cnt = 0;
  // failure counters per checking process
  int       err_cnt = 0;
  int       miss_cnt = 0;
  int       cmp_cnt = 0;
  int       rst_cnt = 0;

  // apply one request to the model, return the owed response
  function automatic bus_rsp_t model_access(bus_req_t r);
    bus_rsp_t       e;
    logic [IDX-1:0] i;
    i     = r.adr[IDX-1:0];
    e.err = (r.adr >= `BUS_MEM_DEPTH);
    e.rdt = '0;
    if (!e.err && r.wen) begin
      for (int b = 0; b < `BUS_BEN; b++) begin
        if (r.ben[b]) begin
          ref_mem[i][b*`BUS_UNT +: `BUS_UNT] = r.wdt.wrd[b*`BUS_UNT +: `BUS_UNT];
        end
      end
    end else if (!e.err) begin
      e.rdt = ref_mem[i];
    end
    return e;
  endfunction

  // pop on each response, push on each transfer
  always @(posedge sub) begin
    if (arst_n) begin
      if (rsp_vld) begin
        if (exp_q.size() != 0) begin
          void'(exp_q.pop_front());
        end
        rsp_cnt++;
      end
      if (req_vld && req_rdy) begin
        exp_q.push_back(model_access(req));
        xfer_cnt++;
      end
      if (req_vld && !req_rdy) begin
        stall_cnt++;
      end
      exp_cnt  = exp_q.size();
      exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
    end
  end

  //////////////////////////////////////////////////
  // checkers
  //////////////////////////////////////////////////

  // outputs sampled mid cycle while stable
  a_rsp_owed: assert property (@(negedge sub) disable iff (!arst_n)
    rsp_vld |-> (exp_cnt != 0))
    else begin
      $display("Fail %0t: response with no request outstanding", $time);
      miss_cnt++;
    end

  a_rsp_match: assert property (@(negedge sub) disable iff (!arst_n)
    rsp_vld |-> (rsp == exp_head))
    else begin
      $display("Fail %0t: got rdt %h err %b, expected rdt %h err %b",
               $time, rsp.rdt, rsp.err, exp_head.rdt, exp_head.err);
      cmp_cnt++;
    end

  // idle handshake while reset is held
  a_rst_state: assert property (@(negedge sub) !arst_n |-> (req_rdy && !rsp_vld))
    else begin
      $display("Fail %0t: req_rdy %b rsp_vld %b during reset", $time, req_rdy, rsp_vld);
      rst_cnt++;
    end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic int total_fails();
    return err_cnt + miss_cnt + cmp_cnt + rst_cnt;
  endfunction

  function automatic logic [`BUS_ADR-1:0] to_adr(int i);
    return i[`BUS_ADR-1:0];
  endfunction

  // every address bit shows up in the word
  function automatic logic [`BUS_DAT-1:0] fill_word(logic [`BUS_ADR-1:0] a);
    return {a, ~a, a ^ 8'h3c, a + 8'h5a};
  endfunction

  function automatic bus_req_t make_req(logic wen, logic [`BUS_ADR-1:0] adr,
                                        logic [`BUS_BEN-1:0] ben,
                                        logic [`BUS_DAT-1:0] wrd);
    bus_req_t r;
    r.wen     = wen;
    r.adr     = adr;
    r.ben     = ben;
    r.wdt.wrd = wrd;
    return r;
  endfunction

  // report the stuck wait and park the stimulus
  task automatic abort(input string what);
    $display("timeout: %s at time %0t", what, $time);
    hung = 1'b1;
    forever @(negedge sub);
  endtask

  // a timed out wait ends the run here
  initial begin
    @(posedge hung);
    $display("=== FAIL ===");
    $finish;
  end

  // drive on the falling edge, hold until the rising edge that transfers
  task automatic send(input bus_req_t r);
    int tmo;
    tmo = 0;
    @(negedge sub);
    req_vld = 1'b1;
    req     = r;
    while (!req_rdy && tmo < TMO) begin
      @(negedge sub);
      tmo++;
    end
    if (!req_rdy) abort("req_rdy stayed low too long");
    @(posedge sub);
  endtask

  task automatic write_word(input logic [`BUS_ADR-1:0] adr,
                            input logic [`BUS_BEN-1:0] ben,
                            input logic [`BUS_DAT-1:0] wrd);
    send(make_req(1'b1, adr, ben, wrd));
  endtask

  task automatic read_word(input logic [`BUS_ADR-1:0] adr);
    send(make_req(1'b0, adr, '0, '0));
  endtask

  task automatic pause(input int n);
    repeat (n) begin
      @(negedge sub);
      req_vld = 1'b0;
    end
  endtask

  // idle until every owed response came back
  task automatic drain();
    int tmo;
    tmo = 0;
    @(negedge sub);
    req_vld = 1'b0;
    while (exp_cnt != 0 && tmo < TMO) begin
      @(negedge sub);
      tmo++;
    end
    if (exp_cnt != 0) abort("responses still outstanding");
  endtask

  task automatic test_done(input int n, input string name, input int base);
    $display("test %0d %s finished with %0d errors", n, name, total_fails() - base);
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [31:0]         rnd;
    logic [`BUS_ADR-1:0] adr;
    logic [`BUS_ADR-1:0] adr_list [16];
    int                  base;
    int                  x0;
    int                  r0;
    int                  s0;
    void'($urandom(32'h4444_2ff5));
    req_vld = 1'b0;
    req     = '0;
    arst_n  = 1'b1;
    exp_cnt = 0;

    // reset for 16 cycles
    base = total_fails();
    @(negedge sub);
    arst_n = 1'b0;
    repeat (16) @(negedge sub);
    arst_n = 1'b1;
    @(negedge sub);
    assert (req_rdy && !rsp_vld) else begin
      $display("Fail %0t: after reset req_rdy %b rsp_vld %b", $time, req_rdy, rsp_vld);
      err_cnt++;
    end
    test_done(1, "reset state", base);

    // fill every word, then read all back
    base = total_fails();
    for (int a = 0; a < `BUS_MEM_DEPTH; a++) begin
      write_word(to_adr(a), '1, fill_word(to_adr(a)));
    end
    for (int a = 0; a < `BUS_MEM_DEPTH; a++) begin
      read_word(to_adr(a));
    end
    drain();
    test_done(2, "full word write and read", base);

    // partial writes over known data
    base = total_fails();
    for (int n = 0; n < 24; n++) begin
      rnd = $urandom_range(`BUS_MEM_DEPTH - 1, 0);
      adr = rnd[`BUS_ADR-1:0];
      rnd = $urandom();
      write_word(adr, rnd[`BUS_BEN-1:0], $urandom());
      // lands in the slice hold register
      write_word(adr, rnd[2*`BUS_BEN-1:`BUS_BEN], $urandom());
      read_word(adr);
      pause($urandom_range(2, 0));
    end
    drain();
    test_done(3, "byte enable merge", base);

    // out of range accesses from the first word past the end on
    base = total_fails();
    write_word(to_adr(`BUS_MEM_DEPTH), '1, $urandom());
    read_word(to_adr(`BUS_MEM_DEPTH));
    for (int n = 0; n < 8; n++) begin
      rnd = $urandom_range((1 << `BUS_ADR) - 1, `BUS_MEM_DEPTH);
      adr = rnd[`BUS_ADR-1:0];
      write_word(adr, '1, $urandom());
      read_word(adr);
    end
    // aliasing would show up here
    for (int a = 0; a < `BUS_MEM_DEPTH; a++) begin
      read_word(to_adr(a));
    end
    drain();
    test_done(4, "address error", base);

    // back to back writes with valid held high
    base = total_fails();
    x0   = xfer_cnt;
    r0   = rsp_cnt;
    s0   = stall_cnt;
    for (int n = 0; n < 16; n++) begin
      rnd         = $urandom_range(`BUS_MEM_DEPTH - 1, 0);
      adr_list[n] = rnd[`BUS_ADR-1:0];
      write_word(adr_list[n], '1, $urandom());
    end
    for (int n = 0; n < 16; n++) begin
      read_word(adr_list[n]);
    end
    drain();
    assert (stall_cnt > s0) else begin
      $display("Fail %0t: req_rdy never dropped during back to back writes", $time);
      err_cnt++;
    end
    assert (rsp_cnt - r0 == xfer_cnt - x0) else begin
      $display("Fail %0t: %0d responses for %0d transfers", $time,
               rsp_cnt - r0, xfer_cnt - x0);
      err_cnt++;
    end
    test_done(5, "back pressure without loss", base);

    // random reads and writes with gaps over a range past the end
    base = total_fails();
    for (int n = 0; n < 80; n++) begin
      rnd = $urandom_range(`BUS_MEM_DEPTH + 7, 0);
      adr = rnd[`BUS_ADR-1:0];
      rnd = $urandom();
      if (rnd[0]) begin
        write_word(adr, rnd[`BUS_BEN:1], $urandom());
      end else begin
        read_word(adr);
      end
      pause($urandom_range(3, 0));
    end
    drain();
    assert (rsp_cnt == xfer_cnt) else begin
      $display("Fail %0t: %0d responses for %0d transfers", $time, rsp_cnt, xfer_cnt);
      err_cnt++;
    end
    test_done(6, "random mix", base);

    $display("6 tests, %0d transfers, %0d responses, %0d errors",
             xfer_cnt, rsp_cnt, total_fails());
    if (total_fails() == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : tb_bus_subsystem

`default_nettype wire

// File: compile.f
+incdir+hdl
hdl/bus_pkg.sv
hdl/bus_reg_backpressure.sv
hdl/bus_sram.sv
hdl/bus_rsp_stage.sv
hdl/bus_subsystem.sv
tb/tb_bus_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# build the bus subsystem testbench with Verilator and run it

# work from the project root
cd "$(dirname "$0")" || exit 1

# compile and link the simulator
verilator --binary --assert --top-module tb_bus_subsystem -Mdir obj_dir -f compile.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# run and keep the output for the search
out=$(./obj_dir/Vtb_bus_subsystem)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# verdict from the testbench output
if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
  exit 0
else
  echo "pass message not found in simulation output"
  exit 1
fi
